// ==== rtl/cfg_pkg.sv ====
// game configuration constants
// game codes, download indexes, DIP bank size, fixed port bytes
package cfg_pkg;

	// ==================================================
	// cpu input ports and download bus
	// ==================================================
	localparam int port_width = 8;
	localparam int orient_width = 2;
	localparam int dl_index_width = 8;
	localparam int dl_addr_width = 25;

	// download index selects the target register
	localparam logic [dl_index_width-1:0] dl_index_game = 8'd1;
	localparam logic [dl_index_width-1:0] dl_index_dip = 8'd254;

	// ==================================================
	// games
	// ==================================================
	// codes as written by the menu core
	localparam logic [port_width-1:0] game_shollow = 8'd0;
	localparam logic [port_width-1:0] game_wacko = 8'd3;
	localparam logic [port_width-1:0] game_domino = 8'd5;

	// screen orientation
	localparam logic [orient_width-1:0] orient_horz = 2'b00;
	localparam logic [orient_width-1:0] orient_vert = 2'b01;

	// fixed port bytes, active low
	localparam logic [port_width-1:0] port3_shollow = 8'hFD;
	localparam logic [port_width-1:0] port3_upright = 8'hBF;
	localparam logic [port_width-1:0] port_idle = 8'hFF;

	localparam int dip_banks_default = 8;

endpackage

// ==== rtl/ctrl_pkg.sv ====
// player control constants
// keyboard scan codes, joystick bit positions, word widths
package ctrl_pkg;

	// ==================================================
	// word widths
	// ==================================================
	// keyboard event word from the io block
	localparam int ps2_key_width = 11;
	localparam int ps2_toggle_bit = 10;
	localparam int ps2_pressed_bit = 9;
	localparam int ps2_code_width = 8;
	// digital joystick word
	localparam int joy_width = 16;
	// signed relative mouse step
	localparam int mouse_delta_width = 9;

	// ==================================================
	// joystick bit positions
	// ==================================================
	localparam int joy_bit_right = 0;
	localparam int joy_bit_left = 1;
	localparam int joy_bit_down = 2;
	localparam int joy_bit_up = 3;
	localparam int joy_bit_fire_a = 4;
	localparam int joy_bit_fire_b = 5;
	localparam int joy_bit_start = 10;
	localparam int joy_bit_coin = 11;

	// ==================================================
	// scan codes
	// ==================================================
	// player 1 on cursor keys, space and alt
	localparam logic [ps2_code_width-1:0] scan_up1 = 8'h75;
	localparam logic [ps2_code_width-1:0] scan_down1 = 8'h72;
	localparam logic [ps2_code_width-1:0] scan_left1 = 8'h6B;
	localparam logic [ps2_code_width-1:0] scan_right1 = 8'h74;
	localparam logic [ps2_code_width-1:0] scan_fire1a = 8'h29;
	localparam logic [ps2_code_width-1:0] scan_fire1b = 8'h11;
	// F1 and the MAME style "1"
	localparam logic [ps2_code_width-1:0] scan_start1_a = 8'h05;
	localparam logic [ps2_code_width-1:0] scan_start1_b = 8'h16;
	// ESC and "5"
	localparam logic [ps2_code_width-1:0] scan_coin1_a = 8'h76;
	localparam logic [ps2_code_width-1:0] scan_coin1_b = 8'h2E;
	// F2 and "2"
	localparam logic [ps2_code_width-1:0] scan_start2_a = 8'h06;
	localparam logic [ps2_code_width-1:0] scan_start2_b = 8'h1E;
	localparam logic [ps2_code_width-1:0] scan_coin2 = 8'h36;
	// player 2 on R F D G, A and S
	localparam logic [ps2_code_width-1:0] scan_up2 = 8'h2D;
	localparam logic [ps2_code_width-1:0] scan_down2 = 8'h2B;
	localparam logic [ps2_code_width-1:0] scan_left2 = 8'h23;
	localparam logic [ps2_code_width-1:0] scan_right2 = 8'h34;
	localparam logic [ps2_code_width-1:0] scan_fire2a = 8'h1C;
	localparam logic [ps2_code_width-1:0] scan_fire2b = 8'h1B;

endpackage

// ==== rtl/input_port_mapper.sv ====
// game select and DIP registers loaded over the download strobe
// registered per-game assembly of the five cpu input ports
`timescale 1ns/1ps

module input_port_mapper #(
	parameter int pos_width = 11,
	parameter int dip_banks = cfg_pkg::dip_banks_default
) (
	input  logic                                clk_sys,
	input  logic                                arst_n,
	input  logic                                up1,
	input  logic                                down1,
	input  logic                                left1,
	input  logic                                right1,
	input  logic                                fire1a,
	input  logic                                fire1b,
	input  logic                                start1,
	input  logic                                coin1,
	input  logic                                up2,
	input  logic                                down2,
	input  logic                                left2,
	input  logic                                right2,
	input  logic                                fire2a,
	input  logic                                fire2b,
	input  logic                                start2,
	input  logic                                coin2,
	input  logic signed [pos_width-1:0]         x_pos,
	input  logic signed [pos_width-1:0]         y_pos,
	input  logic                                ioctl_wr,
	input  logic [cfg_pkg::dl_index_width-1:0]  ioctl_index,
	input  logic [cfg_pkg::dl_addr_width-1:0]   ioctl_addr,
	input  logic [cfg_pkg::port_width-1:0]      ioctl_dout,
	output logic [cfg_pkg::port_width-1:0]      input_0,
	output logic [cfg_pkg::port_width-1:0]      input_1,
	output logic [cfg_pkg::port_width-1:0]      input_2,
	output logic [cfg_pkg::port_width-1:0]      input_3,
	output logic [cfg_pkg::port_width-1:0]      input_4,
	output logic [cfg_pkg::orient_width-1:0]    orientation
);
	import cfg_pkg::*;

	localparam int dip_sel_width = (dip_banks > 1) ? $clog2(dip_banks) : 1;

	logic                     game_wr;
	logic                     dip_wr;
	logic [dip_sel_width-1:0] dip_sel;
	logic [port_width-1:0]    game_code;
	logic                     flag_shollow;
	logic                     flag_wacko;
	logic                     flag_domino;
	logic [port_width-1:0]    dip_bank [dip_banks];
	logic [port_width-1:0]    coin_port;
	logic [port_width-1:0]    port0_nxt;
	logic [port_width-1:0]    port1_nxt;
	logic [port_width-1:0]    port2_nxt;
	logic [port_width-1:0]    port3_nxt;
	logic [port_width-1:0]    port4_nxt;
	logic [orient_width-1:0]  orient_nxt;

	// ==================================================
	// download decode
	// ==================================================
	assign game_wr = ioctl_wr && (ioctl_index == dl_index_game);
	// addresses past the bank are dropped
	assign dip_wr = ioctl_wr && (ioctl_index == dl_index_dip)
		&& (ioctl_addr < dl_addr_width'(dip_banks));
	assign dip_sel = ioctl_addr[dip_sel_width-1:0];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			game_code <= game_shollow;
		end else if (game_wr) begin
			game_code <= ioctl_dout;
		end
	end

	// flags one edge behind the code
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			flag_shollow <= 1'b1;
			flag_wacko <= 1'b0;
			flag_domino <= 1'b0;
		end else begin
			flag_shollow <= game_code == game_shollow;
			flag_wacko <= game_code == game_wacko;
			flag_domino <= game_code == game_domino;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < dip_banks; i++) begin
				dip_bank[i] <= '0;
			end
		end else if (dip_wr) begin
			dip_bank[dip_sel] <= ioctl_dout;
		end
	end

	// ==================================================
	// per-game port map
	// ==================================================
	// coin and start layout shared by two games
	assign coin_port = ~{4'b0000, start2, start1, coin2, coin1};

	always_comb begin
		// unknown games read the first DIP byte on port 3
		orient_nxt = orient_horz;
		port0_nxt = port_idle;
		port1_nxt = port_idle;
		port2_nxt = port_idle;
		port3_nxt = dip_bank[0];
		port4_nxt = port_idle;
		if (flag_shollow) begin
			port0_nxt = coin_port;
			port1_nxt = ~{fire2a, fire2b, right2, left2, fire1a, fire1b, right1, left1};
			port3_nxt = port3_shollow;
		end else if (flag_wacko) begin
			orient_nxt = orient_vert;
			port0_nxt = coin_port;
			// trackball position read straight, not inverted
			port1_nxt = x_pos[pos_width-1 -: port_width];
			port2_nxt = y_pos[pos_width-1 -: port_width];
			port3_nxt = port3_upright;
			port4_nxt = ~{up2, down2, left2, right2, up1, down1, left1, right1};
		end else if (flag_domino) begin
			orient_nxt = orient_vert;
			port0_nxt = ~{3'b000, fire1a, start2, start1, coin2, coin1};
			port1_nxt = ~{4'b0000, down1, up1, right1, left1};
			port2_nxt = ~{3'b000, fire2a, down2, up2, right2, left2};
			port3_nxt = port3_upright;
		end
	end

	// reset shows the Satan's Hollow idle map
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			input_0 <= port_idle;
			input_1 <= port_idle;
			input_2 <= port_idle;
			input_3 <= port3_shollow;
			input_4 <= port_idle;
			orientation <= orient_horz;
		end else begin
			input_0 <= port0_nxt;
			input_1 <= port1_nxt;
			input_2 <= port2_nxt;
			input_3 <= port3_nxt;
			input_4 <= port4_nxt;
			orientation <= orient_nxt;
		end
	end

	// a write with unknown fields would load garbage into the game or DIP registers
	a_dl_known: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ioctl_wr |-> !$isunknown({ioctl_index, ioctl_addr, ioctl_dout}));

endmodule

// ==== rtl/mcr2_input_top.sv ====
// player input front end for the MCR2 family
// key and joystick decode, mouse tracking, per-game port map
`timescale 1ns/1ps

module mcr2_input_top #(
	parameter int pos_width = 11,
	parameter int dip_banks = cfg_pkg::dip_banks_default
) (
	input  logic                                  clk_sys,
	input  logic                                  arst_n,
	input  logic [ctrl_pkg::ps2_key_width-1:0]    ps2_key,
	input  logic [ctrl_pkg::joy_width-1:0]        joy1,
	input  logic [ctrl_pkg::joy_width-1:0]        joy2,
	input  logic signed [ctrl_pkg::mouse_delta_width-1:0] mouse_x,
	input  logic signed [ctrl_pkg::mouse_delta_width-1:0] mouse_y,
	input  logic                                  mouse_strobe,
	input  logic                                  ioctl_wr,
	input  logic [cfg_pkg::dl_index_width-1:0]    ioctl_index,
	input  logic [cfg_pkg::dl_addr_width-1:0]     ioctl_addr,
	input  logic [cfg_pkg::port_width-1:0]        ioctl_dout,
	output logic [cfg_pkg::port_width-1:0]        input_0,
	output logic [cfg_pkg::port_width-1:0]        input_1,
	output logic [cfg_pkg::port_width-1:0]        input_2,
	output logic [cfg_pkg::port_width-1:0]        input_3,
	output logic [cfg_pkg::port_width-1:0]        input_4,
	output logic [cfg_pkg::orient_width-1:0]      orientation
);

	// merged buttons
	logic up1;
	logic down1;
	logic left1;
	logic right1;
	logic fire1a;
	logic fire1b;
	logic start1;
	logic coin1;
	logic up2;
	logic down2;
	logic left2;
	logic right2;
	logic fire2a;
	logic fire2b;
	logic start2;
	logic coin2;

	// trackball position
	logic signed [pos_width-1:0] x_pos;
	logic signed [pos_width-1:0] y_pos;

	// port names match across the blocks
	player_controls u_player_controls (.*);

	mouse_tracker #(
		.pos_width(pos_width)
	) u_mouse_tracker (.*);

	input_port_mapper #(
		.pos_width(pos_width),
		.dip_banks(dip_banks)
	) u_input_port_mapper (.*);

endmodule

// ==== rtl/mouse_tracker.sv ====
// relative mouse position accumulators
`timescale 1ns/1ps

module mouse_tracker #(
	parameter int pos_width = 11
) (
	input  logic                                        clk_sys,
	input  logic                                        arst_n,
	input  logic                                        mouse_strobe,
	input  logic signed [ctrl_pkg::mouse_delta_width-1:0] mouse_x,
	input  logic signed [ctrl_pkg::mouse_delta_width-1:0] mouse_y,
	output logic signed [pos_width-1:0]                 x_pos,
	output logic signed [pos_width-1:0]                 y_pos
);
	import ctrl_pkg::*;

	// sign bits needed to widen a step to the accumulator
	localparam int ext_width = pos_width - mouse_delta_width;

	logic signed [pos_width-1:0] step_x;
	logic signed [pos_width-1:0] step_y;

	assign step_x = {{ext_width{mouse_x[mouse_delta_width-1]}}, mouse_x};
	assign step_y = {{ext_width{mouse_y[mouse_delta_width-1]}}, mouse_y};

	// ==================================================
	// accumulators
	// ==================================================
	// overflow wraps around
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			x_pos <= '0;
			y_pos <= '0;
		end else if (mouse_strobe) begin
			x_pos <= x_pos + step_x;
			y_pos <= y_pos + step_y;
		end
	end

	// a step sampled with X bits would poison the sum for good
	a_delta_known: assert property (@(posedge clk_sys) disable iff (!arst_n)
		mouse_strobe |-> !$isunknown({mouse_x, mouse_y}));

endmodule

// ==== rtl/player_controls.sv ====
// keyboard decode into held buttons for two players
// merged with the joystick words
`timescale 1ns/1ps

module player_controls (
	input  logic                           clk_sys,
	input  logic                           arst_n,
	input  logic [ctrl_pkg::ps2_key_width-1:0] ps2_key,
	input  logic [ctrl_pkg::joy_width-1:0] joy1,
	input  logic [ctrl_pkg::joy_width-1:0] joy2,
	// player 1
	output logic                           up1,
	output logic                           down1,
	output logic                           left1,
	output logic                           right1,
	output logic                           fire1a,
	output logic                           fire1b,
	output logic                           start1,
	output logic                           coin1,
	// player 2
	output logic                           up2,
	output logic                           down2,
	output logic                           left2,
	output logic                           right2,
	output logic                           fire2a,
	output logic                           fire2b,
	output logic                           start2,
	output logic                           coin2
);
	import ctrl_pkg::*;

	logic                      prev_toggle;
	logic                      key_event;
	logic                      key_pressed;
	logic [ps2_code_width-1:0] key_code;

	// held key state
	logic held_up1;
	logic held_down1;
	logic held_left1;
	logic held_right1;
	logic held_fire1a;
	logic held_fire1b;
	logic held_start1;
	logic held_coin1;
	logic held_up2;
	logic held_down2;
	logic held_left2;
	logic held_right2;
	logic held_fire2a;
	logic held_fire2b;
	logic held_start2;
	logic held_coin2;

	// any flip of the toggle bit marks a new event
	assign key_event = prev_toggle != ps2_key[ps2_toggle_bit];
	assign key_pressed = ps2_key[ps2_pressed_bit];
	assign key_code = ps2_key[ps2_code_width-1:0];

	// ==================================================
	// held button registers
	// ==================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			prev_toggle <= 1'b0;
			held_up1 <= 1'b0;
			held_down1 <= 1'b0;
			held_left1 <= 1'b0;
			held_right1 <= 1'b0;
			held_fire1a <= 1'b0;
			held_fire1b <= 1'b0;
			held_start1 <= 1'b0;
			held_coin1 <= 1'b0;
			held_up2 <= 1'b0;
			held_down2 <= 1'b0;
			held_left2 <= 1'b0;
			held_right2 <= 1'b0;
			held_fire2a <= 1'b0;
			held_fire2b <= 1'b0;
			held_start2 <= 1'b0;
			held_coin2 <= 1'b0;
		end else begin
			prev_toggle <= ps2_key[ps2_toggle_bit];
			if (key_event) begin
				// alternate codes land on the same button
				case (key_code)
					scan_up1: held_up1 <= key_pressed;
					scan_down1: held_down1 <= key_pressed;
					scan_left1: held_left1 <= key_pressed;
					scan_right1: held_right1 <= key_pressed;
					scan_fire1a: held_fire1a <= key_pressed;
					scan_fire1b: held_fire1b <= key_pressed;
					scan_start1_a, scan_start1_b: held_start1 <= key_pressed;
					scan_coin1_a, scan_coin1_b: held_coin1 <= key_pressed;
					scan_up2: held_up2 <= key_pressed;
					scan_down2: held_down2 <= key_pressed;
					scan_left2: held_left2 <= key_pressed;
					scan_right2: held_right2 <= key_pressed;
					scan_fire2a: held_fire2a <= key_pressed;
					scan_fire2b: held_fire2b <= key_pressed;
					scan_start2_a, scan_start2_b: held_start2 <= key_pressed;
					scan_coin2: held_coin2 <= key_pressed;
					default: ;
				endcase
			end
		end
	end

	// joystick bits bypass the registers
	assign up1 = held_up1 | joy1[joy_bit_up];
	assign down1 = held_down1 | joy1[joy_bit_down];
	assign left1 = held_left1 | joy1[joy_bit_left];
	assign right1 = held_right1 | joy1[joy_bit_right];
	assign fire1a = held_fire1a | joy1[joy_bit_fire_a];
	assign fire1b = held_fire1b | joy1[joy_bit_fire_b];
	assign start1 = held_start1 | joy1[joy_bit_start];
	assign coin1 = held_coin1 | joy1[joy_bit_coin];
	assign up2 = held_up2 | joy2[joy_bit_up];
	assign down2 = held_down2 | joy2[joy_bit_down];
	assign left2 = held_left2 | joy2[joy_bit_left];
	assign right2 = held_right2 | joy2[joy_bit_right];
	assign fire2a = held_fire2a | joy2[joy_bit_fire_a];
	assign fire2b = held_fire2b | joy2[joy_bit_fire_b];
	assign start2 = held_start2 | joy2[joy_bit_start];
	assign coin2 = held_coin2 | joy2[joy_bit_coin];

	// an unknown event word would corrupt the held state on the next edge
	a_key_known: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!$isunknown(ps2_key));

endmodule

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f verilog.f --top-module tb_mcr2_input -o sim_tb > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 \
	|| { cat sim.log; echo "simulator exited with an error"; exit 1; }

cat sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "no pass line in the log"; exit 1; }
echo "simulation passed"

// ==== verification/input_checker.sv ====
// compares the DUT ports against the expected row values
// counts checks and mismatches for the closing report
`timescale 1ns/1ps

module input_checker (
	input  logic                             clk_sys,
	input  logic                             check_en,
	input  int                               check_row,
	// probes on the DUT ports
	input  logic [cfg_pkg::port_width-1:0]   input_0,
	input  logic [cfg_pkg::port_width-1:0]   input_1,
	input  logic [cfg_pkg::port_width-1:0]   input_2,
	input  logic [cfg_pkg::port_width-1:0]   input_3,
	input  logic [cfg_pkg::port_width-1:0]   input_4,
	input  logic [cfg_pkg::orient_width-1:0] orientation,
	// expected values of the current row
	input  logic [cfg_pkg::port_width-1:0]   exp_0,
	input  logic [cfg_pkg::port_width-1:0]   exp_1,
	input  logic [cfg_pkg::port_width-1:0]   exp_2,
	input  logic [cfg_pkg::port_width-1:0]   exp_3,
	input  logic [cfg_pkg::port_width-1:0]   exp_4,
	input  logic [cfg_pkg::orient_width-1:0] exp_orient,
	output int                               error_count,
	output int                               check_count
);
	import cfg_pkg::*;

	int errors = 0;
	int checks = 0;

	assign error_count = errors;
	assign check_count = checks;

	// one byte against its expected value, X counts as wrong
	task automatic compare_byte(input string name, input logic [port_width-1:0] got,
		input logic [port_width-1:0] expected);
		if (got !== expected) begin
			errors++;
			$display("FAIL row %0d %s: got 0x%h expected 0x%h", check_row, name, got,
				expected);
		end
	endtask

	// ==================================================
	// sampling
	// ==================================================
	// strobe is raised on a falling edge, ports idle for several cycles by then
	always @(posedge clk_sys) begin
		if (check_en) begin
			checks++;
			compare_byte("input_0", input_0, exp_0);
			compare_byte("input_1", input_1, exp_1);
			compare_byte("input_2", input_2, exp_2);
			compare_byte("input_3", input_3, exp_3);
			compare_byte("input_4", input_4, exp_4);
			compare_byte("orientation", {6'd0, orientation}, {6'd0, exp_orient});
		end
	end

endmodule

// ==== verification/tb_mcr2_input.sv ====
// testbench for the MCR2 input front end
// clock, reset, stimulus table, watchdog, DUT and checker instances
`timescale 1ns/1ps

module tb_mcr2_input;
	import ctrl_pkg::*;
	import cfg_pkg::*;

	localparam int pos_width = 11;
	localparam int dip_banks = 8;
	localparam int max_rows = 80;
	// key column of a row without a key event
	localparam int no_key = -1;
	// index column of a row without a download write
	localparam logic [dl_index_width-1:0] no_wr = 8'd0;

	// dut inputs
	logic                               clk_sys;
	logic                               arst_n;
	logic [ps2_key_width-1:0]           ps2_key;
	logic [joy_width-1:0]               joy1;
	logic [joy_width-1:0]               joy2;
	logic signed [mouse_delta_width-1:0] mouse_x;
	logic signed [mouse_delta_width-1:0] mouse_y;
	logic                               mouse_strobe;
	logic                               ioctl_wr;
	logic [dl_index_width-1:0]          ioctl_index;
	logic [dl_addr_width-1:0]           ioctl_addr;
	logic [port_width-1:0]              ioctl_dout;
	// dut outputs
	logic [port_width-1:0]              input_0;
	logic [port_width-1:0]              input_1;
	logic [port_width-1:0]              input_2;
	logic [port_width-1:0]              input_3;
	logic [port_width-1:0]              input_4;
	logic [orient_width-1:0]            orientation;
	// checker side
	logic [port_width-1:0]              exp_0;
	logic [port_width-1:0]              exp_1;
	logic [port_width-1:0]              exp_2;
	logic [port_width-1:0]              exp_3;
	logic [port_width-1:0]              exp_4;
	logic [orient_width-1:0]            exp_orient;
	logic                               check_en;
	int                                 check_row;
	int                                 error_count;
	int                                 check_count;

	// ==================================================
	// stimulus table
	// ==================================================
	logic [dl_index_width-1:0] r_index [max_rows];
	logic [dl_addr_width-1:0]  r_addr [max_rows];
	logic [port_width-1:0]     r_data [max_rows];
	int                        r_key [max_rows];
	logic [joy_width-1:0]      r_joy1 [max_rows];
	logic [joy_width-1:0]      r_joy2 [max_rows];
	logic                      r_step [max_rows];
	// ports 0 to 4, port 0 in the top byte
	logic [39:0]               r_ports [max_rows];
	logic [orient_width-1:0]   r_orient [max_rows];
	int                        n_rows = 0;
	logic                      table_ready = 1'b0;

	// reference trackball sums as plain integers, low pos_width bits wrap
	int                           x_sum;
	int                           y_sum;
	logic [mouse_delta_width-1:0] dx;
	logic [mouse_delta_width-1:0] dy;
	logic [31:0]                  rnd;
	logic                         missed;

	mcr2_input_top #(
		.pos_width(pos_width),
		.dip_banks(dip_banks)
	) u_mcr2_input_top (.*);

	input_checker u_input_checker (.*);

	function automatic int key_dn(input logic [7:0] code);
		return 32'h100 | int'(code);
	endfunction

	function automatic int key_up(input logic [7:0] code);
		return int'(code);
	endfunction

	task automatic add_row(input logic [7:0] index, input int addr, input logic [7:0] data,
		input int key, input logic [15:0] j1, input logic [15:0] j2, input logic step,
		input logic [39:0] ports, input logic [1:0] orient);
		r_index[n_rows] = index;
		r_addr[n_rows] = 25'(addr);
		r_data[n_rows] = data;
		r_key[n_rows] = key;
		r_joy1[n_rows] = j1;
		r_joy2[n_rows] = j2;
		r_step[n_rows] = step;
		r_ports[n_rows] = ports;
		r_orient[n_rows] = orient;
		n_rows++;
	endtask

	task automatic key_row(input int key, input logic [39:0] ports, input logic [1:0] orient);
		add_row(no_wr, 0, 8'h00, key, 16'h0, 16'h0, 1'b0, ports, orient);
	endtask

	task automatic joy_row(input logic [15:0] j1, input logic [15:0] j2,
		input logic [39:0] ports, input logic [1:0] orient);
		add_row(no_wr, 0, 8'h00, no_key, j1, j2, 1'b0, ports, orient);
	endtask

	task automatic download_row(input logic [7:0] index, input int addr, input logic [7:0] data,
		input logic [39:0] ports, input logic [1:0] orient);
		add_row(index, addr, data, no_key, 16'h0, 16'h0, 1'b0, ports, orient);
	endtask

	// input_1 and input_2 come from the running sums instead
	task automatic mouse_row(input logic [39:0] ports, input logic [1:0] orient);
		add_row(no_wr, 0, 8'h00, no_key, 16'h0, 16'h0, 1'b1, ports, orient);
	endtask

	task automatic build_table();
		// reset map, Satan's Hollow idle
		key_row(no_key, 40'hFF_FF_FF_FD_FF, 2'd0);
		// presses pile up on input_1 then input_0
		key_row(key_dn(scan_left1), 40'hFF_FE_FF_FD_FF, 2'd0);
		key_row(key_dn(scan_right1), 40'hFF_FC_FF_FD_FF, 2'd0);
		key_row(key_dn(scan_fire1a), 40'hFF_F4_FF_FD_FF, 2'd0);
		key_row(key_dn(scan_fire1b), 40'hFF_F0_FF_FD_FF, 2'd0);
		key_row(key_dn(scan_left2), 40'hFF_E0_FF_FD_FF, 2'd0);
		key_row(key_dn(scan_right2), 40'hFF_C0_FF_FD_FF, 2'd0);
		key_row(key_dn(scan_fire2a), 40'hFF_40_FF_FD_FF, 2'd0);
		key_row(key_dn(scan_fire2b), 40'hFF_00_FF_FD_FF, 2'd0);
		key_row(key_dn(scan_coin1_a), 40'hFE_00_FF_FD_FF, 2'd0);
		key_row(key_dn(scan_coin2), 40'hFC_00_FF_FD_FF, 2'd0);
		key_row(key_dn(scan_start1_a), 40'hF8_00_FF_FD_FF, 2'd0);
		key_row(key_dn(scan_start2_a), 40'hF0_00_FF_FD_FF, 2'd0);
		// releases in the same order
		key_row(key_up(scan_left1), 40'hF0_01_FF_FD_FF, 2'd0);
		key_row(key_up(scan_right1), 40'hF0_03_FF_FD_FF, 2'd0);
		key_row(key_up(scan_fire1a), 40'hF0_0B_FF_FD_FF, 2'd0);
		key_row(key_up(scan_fire1b), 40'hF0_0F_FF_FD_FF, 2'd0);
		key_row(key_up(scan_left2), 40'hF0_1F_FF_FD_FF, 2'd0);
		key_row(key_up(scan_right2), 40'hF0_3F_FF_FD_FF, 2'd0);
		key_row(key_up(scan_fire2a), 40'hF0_BF_FF_FD_FF, 2'd0);
		key_row(key_up(scan_fire2b), 40'hF0_FF_FF_FD_FF, 2'd0);
		key_row(key_up(scan_coin1_a), 40'hF1_FF_FF_FD_FF, 2'd0);
		key_row(key_up(scan_coin2), 40'hF3_FF_FF_FD_FF, 2'd0);
		key_row(key_up(scan_start1_a), 40'hF7_FF_FF_FD_FF, 2'd0);
		key_row(key_up(scan_start2_a), 40'hFF_FF_FF_FD_FF, 2'd0);
		// alternate codes
		key_row(key_dn(scan_start1_b), 40'hFB_FF_FF_FD_FF, 2'd0);
		key_row(key_up(scan_start1_b), 40'hFF_FF_FF_FD_FF, 2'd0);
		key_row(key_dn(scan_coin1_b), 40'hFE_FF_FF_FD_FF, 2'd0);
		key_row(key_up(scan_coin1_b), 40'hFF_FF_FF_FD_FF, 2'd0);
		key_row(key_dn(scan_start2_b), 40'hF7_FF_FF_FD_FF, 2'd0);
		key_row(key_up(scan_start2_b), 40'hFF_FF_FF_FD_FF, 2'd0);
		// up keys are not on this map, held into Wacko
		key_row(key_dn(scan_up1), 40'hFF_FF_FF_FD_FF, 2'd0);
		key_row(key_dn(scan_up2), 40'hFF_FF_FF_FD_FF, 2'd0);
		// joysticks: right, left, fire a, fire b, then start and coin
		joy_row(16'h0033, 16'h0000, 40'hFF_F0_FF_FD_FF, 2'd0);
		joy_row(16'h0C00, 16'h0C00, 40'hF0_FF_FF_FD_FF, 2'd0);
		joy_row(16'h0000, 16'h0033, 40'hFF_0F_FF_FD_FF, 2'd0);

		// ==================================================
		// Wacko
		// ==================================================
		download_row(dl_index_game, 0, game_wacko, 40'hFF_00_00_BF_77, 2'd1);
		key_row(key_dn(scan_down1), 40'hFF_00_00_BF_73, 2'd1);
		key_row(key_dn(scan_down2), 40'hFF_00_00_BF_33, 2'd1);
		key_row(key_up(scan_up1), 40'hFF_00_00_BF_3B, 2'd1);
		key_row(key_up(scan_down1), 40'hFF_00_00_BF_3F, 2'd1);
		key_row(key_up(scan_up2), 40'hFF_00_00_BF_BF, 2'd1);
		key_row(key_up(scan_down2), 40'hFF_00_00_BF_FF, 2'd1);
		// coin1 plus all four directions of player 1
		joy_row(16'h080F, 16'h0000, 40'hFE_00_00_BF_F0, 2'd1);
		for (int i = 0; i < 10; i++) begin
			mouse_row(40'hFF_00_00_BF_FF, 2'd1);
		end

		// ==================================================
		// Domino Man
		// ==================================================
		download_row(dl_index_game, 0, game_domino, 40'hFF_FF_FF_BF_FF, 2'd1);
		joy_row(16'h001F, 16'h0000, 40'hEF_F0_FF_BF_FF, 2'd1);
		joy_row(16'h0000, 16'h001F, 40'hFF_FF_E0_BF_FF, 2'd1);
		joy_row(16'h0C00, 16'h0C00, 40'hF0_FF_FF_BF_FF, 2'd1);
		// up1 and down2 alone pin the bit order
		joy_row(16'h0008, 16'h0004, 40'hFF_FB_F7_BF_FF, 2'd1);
		key_row(key_dn(scan_fire2a), 40'hFF_FF_EF_BF_FF, 2'd1);
		key_row(key_up(scan_fire2a), 40'hFF_FF_FF_BF_FF, 2'd1);

		// ==================================================
		// DIP bank and unknown game
		// ==================================================
		download_row(dl_index_dip, 0, 8'h5A, 40'hFF_FF_FF_BF_FF, 2'd1);
		download_row(dl_index_game, 0, 8'd2, 40'hFF_FF_FF_5A_FF, 2'd0);
		// ignored writes
		download_row(dl_index_dip, 8, 8'h33, 40'hFF_FF_FF_5A_FF, 2'd0);
		download_row(dl_index_dip, 'h100000, 8'h33, 40'hFF_FF_FF_5A_FF, 2'd0);
		download_row(8'd7, 0, 8'h33, 40'hFF_FF_FF_5A_FF, 2'd0);
		// another bank must not reach port 3
		download_row(dl_index_dip, 1, 8'hC3, 40'hFF_FF_FF_5A_FF, 2'd0);
	endtask

	// ==================================================
	// clock and watchdog
	// ==================================================
	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// 5 cycles per row plus reset plus slack
	initial begin
		wait (table_ready);
		repeat (n_rows * 5 + 16 + 200) @(posedge clk_sys);
		$display("timeout: the stimulus table did not finish in time");
		$display("TEST FAIL");
		$finish;
	end

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		arst_n = 1'b0;
		ps2_key = '0;
		joy1 = '0;
		joy2 = '0;
		mouse_x = '0;
		mouse_y = '0;
		mouse_strobe = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		exp_0 = 8'hFF;
		exp_1 = 8'hFF;
		exp_2 = 8'hFF;
		exp_3 = 8'hFD;
		exp_4 = 8'hFF;
		exp_orient = 2'd0;
		check_en = 1'b0;
		check_row = 0;
		x_sum = 0;
		y_sum = 0;
		missed = 1'b0;
		rnd = $urandom(32'he5b68f0e);
		build_table();
		table_ready = 1'b1;
		repeat (16) @(negedge clk_sys);
		arst_n = 1'b1;

		for (int r = 0; r < n_rows; r++) begin
			@(negedge clk_sys);
			check_en = 1'b0;
			joy1 = r_joy1[r];
			joy2 = r_joy2[r];
			if (r_index[r] != no_wr) begin
				ioctl_wr = 1'b1;
				ioctl_index = r_index[r];
				ioctl_addr = r_addr[r];
				ioctl_dout = r_data[r];
			end
			// new event: flip the toggle bit
			if (r_key[r] != no_key) begin
				ps2_key = {~ps2_key[ps2_toggle_bit], r_key[r][8], 1'b0, r_key[r][7:0]};
			end
			if (r_step[r]) begin
				rnd = $urandom();
				dx = rnd[8:0];
				dy = rnd[24:16];
				mouse_x = dx;
				mouse_y = dy;
				mouse_strobe = 1'b1;
				// deltas are two's complement steps
				x_sum = x_sum + int'($signed(dx));
				y_sum = y_sum + int'($signed(dy));
			end
			// strobes last one cycle
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			mouse_strobe = 1'b0;
			repeat (3) @(negedge clk_sys);
			exp_0 = r_ports[r][39:32];
			exp_1 = r_ports[r][31:24];
			exp_2 = r_ports[r][23:16];
			exp_3 = r_ports[r][15:8];
			exp_4 = r_ports[r][7:0];
			exp_orient = r_orient[r];
			if (r_step[r]) begin
				exp_1 = x_sum[pos_width-1 -: port_width];
				exp_2 = y_sum[pos_width-1 -: port_width];
			end
			check_row = r;
			check_en = 1'b1;
		end
		@(negedge clk_sys);
		check_en = 1'b0;
		@(negedge clk_sys);

		if (check_count != n_rows) begin
			$display("only %0d of %0d table rows were checked", check_count, n_rows);
			missed = 1'b1;
		end
		$display("rows %0d, checks %0d, errors %0d", n_rows, check_count, error_count);
		if (error_count == 0 && !missed) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
rtl/ctrl_pkg.sv
rtl/cfg_pkg.sv
rtl/player_controls.sv
rtl/mouse_tracker.sv
rtl/input_port_mapper.sv
rtl/mcr2_input_top.sv
verification/input_checker.sv
verification/tb_mcr2_input.sv
